// File: rast_pkg.sv
/*
 * Command stream definitions for the rasterizer framebuffer front end.
 * Opcodes, register ids and the bit positions of every field in a
 * command word.
 */
package rast_pkg;

    localparam int CMD_WIDTH = 32;

    // Opcode and register id fields
    localparam int OP_MSB  = 31;
    localparam int OP_LSB  = 28;
    localparam int REG_MSB = 27;
    localparam int REG_LSB = 24;

    // Screen position layout, shared by resolution, scissor and fragment words
    localparam int X_MSB = 21;
    localparam int X_LSB = 11;
    localparam int Y_MSB = 10;
    localparam int Y_LSB = 0;

    // Value field for addresses, colors and enable flags
    localparam int VAL_MSB = 23;
    localparam int VAL_LSB = 0;

    typedef enum logic [3:0] {
        OP_NOP      = 4'h0,
        OP_SET_REG  = 4'h1,
        OP_CLEAR    = 4'h2,
        OP_FRAGMENT = 4'h3,
        OP_COMMIT   = 4'h4
    } cmd_op_t;

    typedef enum logic [3:0] {
        REG_BASE_ADDR      = 4'h0,
        REG_RESOLUTION     = 4'h1,
        REG_SCISSOR_START  = 4'h2,
        REG_SCISSOR_END    = 4'h3,
        REG_SCISSOR_ENABLE = 4'h4,
        REG_CLEAR_COLOR    = 4'h5,
        REG_COLOR_MASK     = 4'h6
    } fb_reg_t;

endpackage

// File: fb_pkg.sv
/*
 * Framebuffer definitions.
 * Pixel and screen position types, the framebuffer configuration set by
 * the command stream, pixel requests and memory write words.
 */
package fb_pkg;

    localparam int SCREEN_POS_WIDTH = 11;
    localparam int ADDR_WIDTH       = 32;
    localparam int PIXEL_WIDTH      = 16;

    typedef logic [SCREEN_POS_WIDTH-1:0] screen_pos_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb888_t;

    // Red in the top five bits, blue in the bottom five
    typedef logic [PIXEL_WIDTH-1:0] rgb565_t;

    typedef struct packed {
        logic [23:0] base_addr;
        screen_pos_t x_res;
        screen_pos_t y_res;
        logic        scissor_en;
        screen_pos_t scissor_x0;
        screen_pos_t scissor_y0;
        screen_pos_t scissor_x1;
        screen_pos_t scissor_y1;
        rgb888_t     clear_color;
        logic        color_en;
    } fb_conf_t;

    typedef struct packed {
        screen_pos_t x;
        screen_pos_t y;
        rgb888_t     color;
    } pix_req_t;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        rgb565_t               data;
    } mem_wr_t;

endpackage

// File: cmd_decoder.sv
/*
 * Command decoder.
 * Takes command words from the valid/ready stream, keeps the framebuffer
 * register file and sequences clears, two-word fragments and frame commits.
 */
`timescale 1ns/1ps

module cmd_decoder
    import rast_pkg::*, fb_pkg::*;
(
    input  logic                 aclk,
    input  logic                 rst,

    input  logic                 cmd_valid,
    output logic                 cmd_ready,
    input  logic [CMD_WIDTH-1:0] cmd_data,

    output fb_conf_t             conf,

    output logic                 clear_start,
    input  logic                 clear_busy,

    output logic                 frag_valid,
    input  logic                 frag_ready,
    output pix_req_t             frag,

    input  logic                 wr_idle,
    output logic                 swap_fb,
    input  logic                 fb_swapped
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FRAG_COLOR,
        ST_FRAG_ISSUE,
        ST_CLEAR,
        ST_DRAIN,
        ST_SWAP
    } state_t;

    state_t                     state;
    cmd_op_t                    op;
    fb_reg_t                    reg_id;
    screen_pos_t                cmd_x;
    screen_pos_t                cmd_y;
    logic [VAL_MSB-VAL_LSB:0]   cmd_val;
    logic                       cmd_fire;
    logic                       idle_fire;

    // Field extraction
    assign op      = cmd_op_t'(cmd_data[OP_MSB:OP_LSB]);
    assign reg_id  = fb_reg_t'(cmd_data[REG_MSB:REG_LSB]);
    assign cmd_x   = cmd_data[X_MSB:X_LSB];
    assign cmd_y   = cmd_data[Y_MSB:Y_LSB];
    assign cmd_val = cmd_data[VAL_MSB:VAL_LSB];

    assign cmd_ready = (state == ST_IDLE) || (state == ST_FRAG_COLOR);
    assign cmd_fire  = cmd_valid && cmd_ready;
    assign idle_fire = cmd_fire && (state == ST_IDLE);

    assign clear_start = idle_fire && (op == OP_CLEAR);
    assign frag_valid  = (state == ST_FRAG_ISSUE);
    assign swap_fb     = (state == ST_SWAP);

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            state <= ST_IDLE;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    if (cmd_valid)
                    begin
                        case (op)
                            OP_CLEAR:    state <= ST_CLEAR;
                            OP_FRAGMENT: state <= ST_FRAG_COLOR;
                            OP_COMMIT:   state <= ST_DRAIN;
                            // SET_REG completes here, NOP and unknown codes are dropped
                            default:     state <= ST_IDLE;
                        endcase
                    end
                end
                ST_FRAG_COLOR:
                    if (cmd_valid)
                        state <= ST_FRAG_ISSUE;
                ST_FRAG_ISSUE:
                    if (frag_ready)
                        state <= ST_IDLE;
                ST_CLEAR:
                    if (!clear_busy)
                        state <= ST_IDLE;
                ST_DRAIN:
                    if (wr_idle)
                        state <= ST_SWAP;
                ST_SWAP:
                    if (fb_swapped)
                        state <= ST_IDLE;
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    // Register file
    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            conf <= '0;
        end
        else if (idle_fire && (op == OP_SET_REG))
        begin
            case (reg_id)
                REG_BASE_ADDR:      conf.base_addr   <= cmd_val;
                REG_RESOLUTION:
                begin
                    conf.x_res <= cmd_x;
                    conf.y_res <= cmd_y;
                end
                REG_SCISSOR_START:
                begin
                    conf.scissor_x0 <= cmd_x;
                    conf.scissor_y0 <= cmd_y;
                end
                REG_SCISSOR_END:
                begin
                    conf.scissor_x1 <= cmd_x;
                    conf.scissor_y1 <= cmd_y;
                end
                REG_SCISSOR_ENABLE: conf.scissor_en  <= cmd_data[VAL_LSB];
                REG_CLEAR_COLOR:    conf.clear_color <= rgb888_t'(cmd_val);
                REG_COLOR_MASK:     conf.color_en    <= cmd_data[VAL_LSB];
                default:            conf             <= conf;
            endcase
        end
    end

    // Fragment position waits here for the color word
    always_ff @(posedge aclk)
    begin
        if (idle_fire && (op == OP_FRAGMENT))
        begin
            frag.x <= cmd_x;
            frag.y <= cmd_y;
        end
        if (cmd_fire && (state == ST_FRAG_COLOR))
            frag.color <= rgb888_t'(cmd_val);
    end

    // A swap must never overlap a running clear in the sweeper
    assert property (@(posedge aclk) disable iff (rst) !(swap_fb && clear_busy));

    assert property (@(posedge aclk) disable iff (rst) clear_start |=> !clear_start);

endmodule

// File: clear_sweeper.sv
/*
 * Clear sweeper.
 * Walks the clear rectangle in row-major order and offers one pixel
 * request per position, carrying the clear color.
 */
`timescale 1ns/1ps

module clear_sweeper
    import fb_pkg::*;
(
    input  logic     aclk,
    input  logic     rst,
    input  fb_conf_t conf,
    input  logic     clear_start,
    output logic     clear_busy,
    output logic     sweep_valid,
    input  logic     sweep_ready,
    output pix_req_t sweep
);

    screen_pos_t rect_x0;
    screen_pos_t rect_y0;
    screen_pos_t rect_x1;
    screen_pos_t rect_y1;
    screen_pos_t cur_x;
    screen_pos_t cur_y;
    screen_pos_t next_x;
    screen_pos_t next_y;
    logic        rect_empty;
    logic        step;

    // Scissor rectangle clamped to the resolution, or the whole screen
    always_comb
    begin
        if (conf.scissor_en)
        begin
            rect_x0 = conf.scissor_x0;
            rect_y0 = conf.scissor_y0;
            rect_x1 = (conf.scissor_x1 < conf.x_res) ? conf.scissor_x1 : conf.x_res;
            rect_y1 = (conf.scissor_y1 < conf.y_res) ? conf.scissor_y1 : conf.y_res;
        end
        else
        begin
            rect_x0 = '0;
            rect_y0 = '0;
            rect_x1 = conf.x_res;
            rect_y1 = conf.y_res;
        end
    end

    assign rect_empty = (rect_x0 >= rect_x1) || (rect_y0 >= rect_y1);
    assign next_x     = cur_x + 1'b1;
    assign next_y     = cur_y + 1'b1;
    assign step       = sweep_valid && sweep_ready;

    assign sweep_valid = clear_busy;
    assign sweep       = '{x: cur_x, y: cur_y, color: conf.clear_color};

    always_ff @(posedge aclk)
    begin
        if (rst)
            clear_busy <= 1'b0;
        else if (clear_start)
            clear_busy <= !rect_empty;
        else if (step && (next_x == rect_x1) && (next_y == rect_y1))
            clear_busy <= 1'b0;
    end

    always_ff @(posedge aclk)
    begin
        if (clear_start)
        begin
            cur_x <= rect_x0;
            cur_y <= rect_y0;
        end
        else if (step)
        begin
            if (next_x == rect_x1)
            begin
                cur_x <= rect_x0;
                cur_y <= next_y;
            end
            else
            begin
                cur_x <= next_x;
            end
        end
    end

    assert property (@(posedge aclk) disable iff (rst)
        sweep_valid |-> (sweep.x >= rect_x0) && (sweep.x < rect_x1)
                     && (sweep.y >= rect_y0) && (sweep.y < rect_y1));

endmodule

// File: fb_write_port.sv
/*
 * Framebuffer write port.
 * Holds one pixel request, applies the scissor and resolution test, reduces
 * the color to RGB565 and issues single-word writes against a credit count.
 */
`timescale 1ns/1ps

module fb_write_port
    import fb_pkg::*;
#(
    parameter int MEM_CREDITS = 4
)
(
    input  logic     aclk,
    input  logic     rst,
    input  fb_conf_t conf,

    input  logic     sweep_valid,
    output logic     sweep_ready,
    input  pix_req_t sweep,

    input  logic     frag_valid,
    output logic     frag_ready,
    input  pix_req_t frag,

    output logic     mem_wr_valid,
    output mem_wr_t  mem_wr,
    input  logic     mem_credit,

    output logic     wr_idle
);

    localparam int CNT_WIDTH = $clog2(MEM_CREDITS + 1);

    pix_req_t             in_req;
    logic                 in_visible;
    logic                 port_ready;
    logic                 accept;
    logic                 held_valid;
    logic                 held_write;
    logic                 held_done;
    mem_wr_t              held_wr;
    logic [CNT_WIDTH-1:0] credit_cnt;
    logic                 credit_avail;

    function automatic rgb565_t to_rgb565(input rgb888_t c);
        to_rgb565 = {c.r[7:3], c.g[7:2], c.b[7:3]};
    endfunction

    // Sweeper has priority over the fragment path
    assign in_req = sweep_valid ? sweep : frag;

    always_comb
    begin
        in_visible = (in_req.x < conf.x_res) && (in_req.y < conf.y_res);
        if (conf.scissor_en)
        begin
            in_visible = in_visible
                && (in_req.x >= conf.scissor_x0) && (in_req.x < conf.scissor_x1)
                && (in_req.y >= conf.scissor_y0) && (in_req.y < conf.scissor_y1);
        end
    end

    assign credit_avail = (credit_cnt != '0);
    // Rejected requests leave without waiting for a credit
    assign held_done    = held_valid && (!held_write || credit_avail);
    assign port_ready   = !held_valid || held_done;
    assign accept       = port_ready && (sweep_valid || frag_valid);

    assign sweep_ready  = port_ready;
    assign frag_ready   = port_ready && !sweep_valid;

    assign mem_wr_valid = held_valid && held_write && credit_avail;
    assign mem_wr       = held_wr;
    assign wr_idle      = !held_valid && (credit_cnt == CNT_WIDTH'(MEM_CREDITS));

    always_ff @(posedge aclk)
    begin
        if (rst)
            held_valid <= 1'b0;
        else if (accept)
            held_valid <= 1'b1;
        else if (held_done)
            held_valid <= 1'b0;
    end

    // Test and address use the configuration seen at acceptance
    always_ff @(posedge aclk)
    begin
        if (accept)
        begin
            held_write   <= in_visible && conf.color_en;
            held_wr.addr <= ADDR_WIDTH'(conf.base_addr)
                            + ADDR_WIDTH'(in_req.y) * ADDR_WIDTH'(conf.x_res)
                            + ADDR_WIDTH'(in_req.x);
            held_wr.data <= to_rgb565(in_req.color);
        end
    end

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            credit_cnt <= CNT_WIDTH'(MEM_CREDITS);
        end
        else
        begin
            case ({mem_wr_valid, mem_credit})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Memory side must not hand back more credits than were used
    assert property (@(posedge aclk) disable iff (rst)
        credit_cnt <= CNT_WIDTH'(MEM_CREDITS));

    assert property (@(posedge aclk) disable iff (rst) mem_wr_valid |-> credit_cnt != '0);

endmodule

// File: renderer_top.sv
/*
 * Framebuffer renderer top level.
 * Command decoder, clear sweeper and credit-gated write port.
 */
`timescale 1ns/1ps

module renderer_top
    import rast_pkg::*, fb_pkg::*;
#(
    parameter int MEM_CREDITS = 4
)
(
    input  logic                  aclk,
    input  logic                  rst,

    input  logic                  cmd_valid,
    output logic                  cmd_ready,
    input  logic [CMD_WIDTH-1:0]  cmd_data,

    output logic                  mem_wr_valid,
    output mem_wr_t               mem_wr,
    input  logic                  mem_credit,

    output logic                  swap_fb,
    input  logic                  fb_swapped,
    output logic [ADDR_WIDTH-1:0] fb_addr
);

    fb_conf_t conf;
    logic     clear_start;
    logic     clear_busy;
    logic     sweep_valid;
    logic     sweep_ready;
    pix_req_t sweep;
    logic     frag_valid;
    logic     frag_ready;
    pix_req_t frag;
    logic     wr_idle;

    assign fb_addr = ADDR_WIDTH'(conf.base_addr);

    cmd_decoder decoder (
        .aclk        (aclk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_data    (cmd_data),
        .conf        (conf),
        .clear_start (clear_start),
        .clear_busy  (clear_busy),
        .frag_valid  (frag_valid),
        .frag_ready  (frag_ready),
        .frag        (frag),
        .wr_idle     (wr_idle),
        .swap_fb     (swap_fb),
        .fb_swapped  (fb_swapped)
    );

    clear_sweeper sweeper (
        .aclk        (aclk),
        .rst         (rst),
        .conf        (conf),
        .clear_start (clear_start),
        .clear_busy  (clear_busy),
        .sweep_valid (sweep_valid),
        .sweep_ready (sweep_ready),
        .sweep       (sweep)
    );

    fb_write_port #(
        .MEM_CREDITS (MEM_CREDITS)
    ) write_port (
        .aclk         (aclk),
        .rst          (rst),
        .conf         (conf),
        .sweep_valid  (sweep_valid),
        .sweep_ready  (sweep_ready),
        .sweep        (sweep),
        .frag_valid   (frag_valid),
        .frag_ready   (frag_ready),
        .frag         (frag),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr),
        .mem_credit   (mem_credit),
        .wr_idle      (wr_idle)
    );

endmodule

// File: tb_renderer.sv
/*
 * Testbench for the framebuffer renderer.
 * Drives the command stream, models memory with delayed credit return and a
 * swap responder, and checks every memory write and the final image.
 */
`timescale 1ns/1ps

module tb_renderer
    import rast_pkg::*, fb_pkg::*;
;

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int MEM_CREDITS    = 4;
    localparam int MEM_WORDS      = 512;
    // At most one screen of pixel requests per test
    localparam int TEST_PIXELS    = 8 * 6 * 6;
    localparam int WATCHDOG_NS    = (TEST_PIXELS * 20 + RESET_CYCLES + 400) * CLK_PERIOD;
    localparam int COMMIT_TIMEOUT = 2000;
    localparam int SWAP_ACK_DELAY = 3;

    logic                  aclk;
    logic                  rst        = 1'b1;
    logic                  cmd_valid  = 1'b0;
    logic                  cmd_ready;
    logic [CMD_WIDTH-1:0]  cmd_data   = '0;
    logic                  mem_wr_valid;
    mem_wr_t               mem_wr;
    logic                  mem_credit = 1'b0;
    logic                  swap_fb;
    logic                  fb_swapped = 1'b0;
    logic [ADDR_WIDTH-1:0] fb_addr;

    logic [15:0] shadow_mem [MEM_WORDS];
    logic [15:0] ref_img [MEM_WORDS];
    logic [31:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int          credit_due [$];

    // Mirror of the framebuffer registers, zero like the DUT after reset
    int          ref_base, ref_xres, ref_yres, ref_sx0, ref_sy0, ref_sx1, ref_sy1;
    bit          ref_sc_en, ref_color_en;
    logic [23:0] ref_clear;

    logic [15:0] lfsr = 16'd61;
    int          delay_bits = 1;
    int          credit_cycle, swap_delay;
    int          write_count, swap_count, in_flight, max_in_flight;
    int          error_count, check_count, tests_run, tests_failed, test_start_errors;
    bit          swap_prev, ack_prev;

    renderer_top #(
        .MEM_CREDITS (MEM_CREDITS)
    ) dut_i (
        .aclk         (aclk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_data     (cmd_data),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr),
        .mem_credit   (mem_credit),
        .swap_fb      (swap_fb),
        .fb_swapped   (fb_swapped),
        .fb_addr      (fb_addr)
    );

    initial
    begin
        aclk = 1'b0;
        forever
            #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int   r;
        logic fb;
        r = 0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = (r << 1) | int'(fb);
        end
        return r;
    endfunction

    function automatic logic [15:0] fill_word(input int a);
        return 16'(a) ^ 16'(a << 7) ^ 16'hC35A;
    endfunction

    function automatic logic [CMD_WIDTH-1:0] make_cmd(input cmd_op_t op,
                                                      input logic [3:0] rid,
                                                      input logic [23:0] val);
        logic [CMD_WIDTH-1:0] w;
        w                  = '0;
        w[OP_MSB:OP_LSB]   = op;
        w[REG_MSB:REG_LSB] = rid;
        w[VAL_MSB:VAL_LSB] = val;
        return w;
    endfunction

    function automatic logic [23:0] xy_val(input int x, input int y);
        logic [23:0] v;
        v              = '0;
        v[X_MSB:X_LSB] = 11'(x);
        v[Y_MSB:Y_LSB] = 11'(y);
        return v;
    endfunction

    // Reference model of one pixel: visibility, RGB565 word and address
    function automatic bit expect_pixel(input int x, input int y, input logic [23:0] color,
                                        output int addr, output logic [15:0] data);
        bit vis;
        vis = (x < ref_xres) && (y < ref_yres);
        if (ref_sc_en)
            vis = vis && (x >= ref_sx0) && (x < ref_sx1) && (y >= ref_sy0) && (y < ref_sy1);
        addr = ref_base + y * ref_xres + x;
        data = {color[23:19], color[15:10], color[7:3]};
        return vis && ref_color_en;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic send_cmd(input logic [CMD_WIDTH-1:0] word);
        cmd_valid <= 1'b1;
        cmd_data  <= word;
        @(posedge aclk);
        while (!cmd_ready)
            @(posedge aclk);
        cmd_valid <= 1'b0;
    endtask

    task automatic set_reg(input fb_reg_t rid, input logic [23:0] val);
        send_cmd(make_cmd(OP_SET_REG, rid, val));
        case (rid)
            REG_BASE_ADDR:      ref_base = int'(val);
            REG_RESOLUTION:
            begin
                ref_xres = int'(val[X_MSB:X_LSB]);
                ref_yres = int'(val[Y_MSB:Y_LSB]);
            end
            REG_SCISSOR_START:
            begin
                ref_sx0 = int'(val[X_MSB:X_LSB]);
                ref_sy0 = int'(val[Y_MSB:Y_LSB]);
            end
            REG_SCISSOR_END:
            begin
                ref_sx1 = int'(val[X_MSB:X_LSB]);
                ref_sy1 = int'(val[Y_MSB:Y_LSB]);
            end
            REG_SCISSOR_ENABLE: ref_sc_en = val[0];
            REG_CLEAR_COLOR:    ref_clear = val;
            REG_COLOR_MASK:     ref_color_en = val[0];
            default:            ;
        endcase
    endtask

    task automatic add_expected(input int x, input int y, input logic [23:0] color);
        int          addr;
        logic [15:0] data;
        if (expect_pixel(x, y, color, addr, data))
        begin
            exp_addr.push_back(32'(addr));
            exp_data.push_back(data);
            ref_img[addr] = data;
        end
    endtask

    // Row-major over the whole screen gives the same order as the sweep
    task automatic clear_screen();
        for (int y = 0; y < ref_yres; y++)
            for (int x = 0; x < ref_xres; x++)
                add_expected(x, y, ref_clear);
        send_cmd(make_cmd(OP_CLEAR, 4'h0, 24'h0));
    endtask

    task automatic draw_fragment(input int x, input int y, input logic [23:0] color);
        add_expected(x, y, color);
        send_cmd(make_cmd(OP_FRAGMENT, 4'h0, xy_val(x, y)));
        send_cmd(make_cmd(OP_NOP, 4'h0, color));
    endtask

    task automatic commit_frame();
        int start;
        int waited;
        start  = swap_count;
        waited = 0;
        send_cmd(make_cmd(OP_COMMIT, 4'h0, 24'h0));
        while ((swap_count == start) && (waited < COMMIT_TIMEOUT))
        begin
            @(posedge aclk);
            waited++;
        end
        if (swap_count == start)
        begin
            $display("[FAIL] commit timed out without a completed swap handshake");
            error_count++;
        end
    endtask

    task automatic check_image();
        for (int a = 0; a < MEM_WORDS; a++)
            check_value($sformatf("mem[0x%0h]", a), 32'(shadow_mem[a]), 32'(ref_img[a]));
    endtask

    task automatic end_test(input int num, input string name);
        int errs;
        errs = error_count - test_start_errors;
        tests_run++;
        if (errs == 0)
            $display("test %0d (%s): pass", num, name);
        else
        begin
            tests_failed++;
            $display("test %0d (%s): fail with %0d errors", num, name, errs);
        end
        test_start_errors = error_count;
    endtask

    // Memory side returns one credit per write after a random delay
    always @(posedge aclk)
    begin
        if (rst)
        begin
            mem_credit <= 1'b0;
            credit_due.delete();
            credit_cycle = 0;
        end
        else
        begin
            credit_cycle++;
            if (mem_wr_valid)
                credit_due.push_back(credit_cycle + 1 + rand_bits(delay_bits));
            if ((credit_due.size() > 0) && (credit_due[0] <= credit_cycle))
            begin
                mem_credit <= 1'b1;
                void'(credit_due.pop_front());
            end
            else
                mem_credit <= 1'b0;
        end
    end

    always @(posedge aclk)
    begin
        if (rst)
        begin
            fb_swapped <= 1'b0;
            swap_delay = 0;
        end
        else if (swap_fb && !fb_swapped)
        begin
            swap_delay++;
            if (swap_delay == SWAP_ACK_DELAY)
            begin
                fb_swapped <= 1'b1;
                swap_delay = 0;
            end
        end
        else
            fb_swapped <= 1'b0;
    end

    // Compare process for writes, credits and the swap handshake
    always @(posedge aclk)
    begin
        if (rst)
        begin
            in_flight = 0;
            swap_prev = 1'b0;
            ack_prev  = 1'b0;
        end
        else
        begin
            if (swap_fb && !swap_prev)
            begin
                check_value("writes in flight at swap", 32'(in_flight), 32'd0);
                check_value("fb_addr", fb_addr, 32'(ref_base));
                if (exp_addr.size() != 0)
                begin
                    $display("[FAIL] swap raised with %0d expected writes missing",
                             exp_addr.size());
                    error_count++;
                end
            end
            if (ack_prev)
            begin
                check_value("swap_fb", 32'(swap_fb), 32'd0);
                swap_count <= swap_count + 1;
            end
            swap_prev = swap_fb;
            ack_prev  = fb_swapped;
            if (mem_wr_valid)
            begin
                if (exp_addr.size() == 0)
                begin
                    $display("[FAIL] memory write to 0x%0h when none was expected", mem_wr.addr);
                    error_count++;
                end
                else
                begin
                    check_value("mem_wr.addr", mem_wr.addr, exp_addr.pop_front());
                    check_value("mem_wr.data", 32'(mem_wr.data), 32'(exp_data.pop_front()));
                end
                if (mem_wr.addr < MEM_WORDS)
                    shadow_mem[mem_wr.addr] = mem_wr.data;
                write_count <= write_count + 1;
                in_flight++;
            end
            if (mem_credit)
                in_flight--;
            if (in_flight > MEM_CREDITS)
            begin
                $display("[FAIL] %0d writes in flight with only %0d credits",
                         in_flight, MEM_CREDITS);
                error_count++;
            end
            if (in_flight > max_in_flight)
                max_in_flight = in_flight;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("[FAIL] watchdog expired after %0d ns, the run is stuck", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin
        int w0;
        for (int a = 0; a < MEM_WORDS; a++)
        begin
            shadow_mem[a] = fill_word(a);
            ref_img[a]    = fill_word(a);
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        rst <= 1'b0;
        @(posedge aclk);

        check_value("cmd_ready", 32'(cmd_ready), 32'd1);
        check_value("mem_wr_valid", 32'(mem_wr_valid), 32'd0);
        check_value("swap_fb", 32'(swap_fb), 32'd0);
        set_reg(REG_BASE_ADDR, 24'h100);
        set_reg(REG_RESOLUTION, xy_val(8, 6));
        set_reg(REG_CLEAR_COLOR, 24'hFF8040);
        w0 = write_count;
        clear_screen();
        commit_frame();
        check_value("write_count", write_count - w0, 32'd0);
        check_image();
        end_test(1, "reset state and masked clear");

        set_reg(REG_COLOR_MASK, 24'h1);
        set_reg(REG_CLEAR_COLOR, 24'h12ABF0);
        w0 = write_count;
        clear_screen();
        commit_frame();
        check_value("write_count", write_count - w0, 32'd48);
        check_image();
        end_test(2, "full clear");

        set_reg(REG_CLEAR_COLOR, 24'h3C5A96);
        set_reg(REG_SCISSOR_START, xy_val(2, 1));
        set_reg(REG_SCISSOR_END, xy_val(6, 4));
        set_reg(REG_SCISSOR_ENABLE, 24'h1);
        w0 = write_count;
        clear_screen();
        commit_frame();
        check_value("write_count", write_count - w0, 32'd12);
        check_image();
        end_test(3, "scissor clear");

        w0 = write_count;
        draw_fragment(3, 2, 24'h102030);
        draw_fragment(0, 0, 24'hFFFFFF);
        draw_fragment(5, 3, 24'h80FF80);
        draw_fragment(6, 4, 24'hE01F07);
        set_reg(REG_SCISSOR_ENABLE, 24'h0);
        draw_fragment(7, 5, 24'hA5A5A5);
        draw_fragment(8, 0, 24'h0000FF);
        draw_fragment(2, 6, 24'hFF0000);
        draw_fragment(0, 0, 24'h00FF00);
        commit_frame();
        check_value("write_count", write_count - w0, 32'd4);
        check_image();
        end_test(4, "fragments and visibility");

        delay_bits    = 4;
        max_in_flight = 0;
        set_reg(REG_CLEAR_COLOR, 24'h9CE231);
        w0 = write_count;
        clear_screen();
        draw_fragment(1, 1, 24'h4080C0);
        draw_fragment(6, 4, 24'hC08040);
        draw_fragment(9, 9, 24'h777777);
        draw_fragment(4, 0, 24'h0F0F0F);
        commit_frame();
        check_value("write_count", write_count - w0, 32'd51);
        check_value("max writes in flight", 32'(max_in_flight), 32'(MEM_CREDITS));
        check_image();
        end_test(5, "credit back-pressure");

        set_reg(REG_BASE_ADDR, 24'h140);
        w0 = write_count;
        draw_fragment(0, 0, 24'hFEDCBA);
        draw_fragment(7, 5, 24'h13579B);
        draw_fragment(3, 3, 24'h2468AC);
        commit_frame();
        check_value("write_count", write_count - w0, 32'd3);
        check_value("fb_addr", fb_addr, 32'h140);
        check_value("swap_fb", 32'(swap_fb), 32'd0);
        check_image();
        end_test(6, "commit and swap");

        $display("tests run %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: verilog.f
rast_pkg.sv
fb_pkg.sv
cmd_decoder.sv
clear_sweeper.sv
fb_write_port.sv
renderer_top.sv
tb_renderer.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the renderer testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_renderer \
    -o tb_renderer_sim \
    && ./obj_dir/tb_renderer_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
